// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_soc
FILELIST  = tb.f
LOG       = sim.log
FAIL_MSG  = Verification failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: common/soc_pkg.sv
// Widths, address map, boot code and region type shared by every block of the SoC harness
`default_nettype none

package soc_pkg;

  // ---------------------------------------------------------------------
  // Bus geometry
  // ---------------------------------------------------------------------
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 64;
  localparam int unsigned BeWidth        = DataWidth / 8;
  localparam int unsigned WordOffsetBits = $clog2(BeWidth);

  // ---------------------------------------------------------------------
  // Address map
  // ---------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0001_0000;
  localparam int unsigned          RomWords    = 8;
  localparam int unsigned          RomIdxWidth = $clog2(RomWords);
  localparam logic [AddrWidth-1:0] RomSize     = AddrWidth'(RomWords * BeWidth);

  // Boot code, first word then padding
  localparam logic [DataWidth-1:0] RomBootWord = 64'h0000_0297_8000_0537;
  localparam logic [DataWidth-1:0] RomNopWord  = 64'h0000_0013_0000_0013;

  localparam logic [AddrWidth-1:0] SramBase     = 32'h8000_0000;
  localparam int unsigned          SramWords    = 256;
  localparam int unsigned          SramIdxWidth = $clog2(SramWords);
  localparam logic [AddrWidth-1:0] SramSize     = AddrWidth'(SramWords * BeWidth);

  // Timer registers inside a 64 KiB window
  localparam logic [AddrWidth-1:0]     ClintBase       = 32'h0200_0000;
  localparam logic [AddrWidth-1:0]     ClintSize       = 32'h0001_0000;
  localparam int unsigned              ClintOffWidth   = 16;
  localparam logic [ClintOffWidth-1:0] ClintCmpOffset  = 16'h4000;
  localparam logic [ClintOffWidth-1:0] ClintTimeOffset = 16'hBFF8;

  // Debug request hold-off after power-on reset
  localparam int unsigned DebugDelayCycles = 32;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  typedef enum logic [1:0] {
    RegionRom,
    RegionSram,
    RegionClint,
    RegionErr
  } region_e;

  // Byte-lane merge of write data into an existing word
  function automatic logic [DataWidth-1:0] merge_bytes(
    input logic [DataWidth-1:0] old_word,
    input logic [DataWidth-1:0] wdata,
    input logic [BeWidth-1:0]   be
  );
    logic [DataWidth-1:0] result;
    result = old_word;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        result[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return result;
  endfunction

endpackage

`default_nettype wire

// File: logic/clint_timer.sv
// Machine timer with mtime counting rtc edges, mtimecmp and the timer interrupt
`default_nettype none

module clint_timer (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              rtc_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [soc_pkg::BeWidth-1:0]       be_i,
  input  logic [soc_pkg::ClintOffWidth-1:0] off_i,
  input  logic [soc_pkg::DataWidth-1:0]     wdata_i,
  output logic [soc_pkg::DataWidth-1:0]     rdata_o,
  output logic                              timer_irq_o
);

  logic [2:0]                          rtc_q;
  logic                                rtc_tick;
  logic [soc_pkg::ClintOffWidth-1:0]   off_word;
  logic                                sel_time;
  logic                                sel_cmp;
  logic [soc_pkg::DataWidth-1:0]       mtime_q;
  logic [soc_pkg::DataWidth-1:0]       mtimecmp_q;
  logic [soc_pkg::DataWidth-1:0]       read_word;
  logic [soc_pkg::DataWidth-1:0]       rdata_q;
  logic                                irq_q;

  // Two sync stages, third stage for the edge
  assign rtc_tick = rtc_q[1] & ~rtc_q[2];

  // Byte offset inside the word does not matter
  assign off_word = {off_i[soc_pkg::ClintOffWidth-1:soc_pkg::WordOffsetBits],
                     {soc_pkg::WordOffsetBits{1'b0}}};
  assign sel_time = (off_word == soc_pkg::ClintTimeOffset);
  assign sel_cmp  = (off_word == soc_pkg::ClintCmpOffset);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q      <= 3'b000;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
      // Software write wins over a tick in the same cycle
      if (req_i && we_i && sel_time) begin
        mtime_q <= soc_pkg::merge_bytes(mtime_q, wdata_i, be_i);
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (req_i && we_i && sel_cmp) begin
        mtimecmp_q <= soc_pkg::merge_bytes(mtimecmp_q, wdata_i, be_i);
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    read_word = '0;
    if (sel_time) begin
      read_word = mtime_q;
    end else if (sel_cmp) begin
      read_word = mtimecmp_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : read_word;
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

// File: logic/debug_ctrl.sv
// Peripheral reset synchronizer and post-reset hold-off for debug requests, used by soc_top
`default_nettype none

module debug_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  output logic periph_rst_no,
  output logic debug_req_o
);

  logic                                 rst_comb_n;
  logic [1:0]                           sync_q;
  logic [soc_pkg::DebugCntWidth-1:0]    delay_cnt_q;

  // ---------------------------------------------------------------------
  // Peripheral reset
  // ---------------------------------------------------------------------
  // Asserts at once, releases on the second edge
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign periph_rst_no = sync_q[1];

  // ---------------------------------------------------------------------
  // Debug request gate
  // ---------------------------------------------------------------------
  // Boot code gets a head start before debug can halt it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_cnt_q <= soc_pkg::DebugCntWidth'(soc_pkg::DebugDelayCycles);
    end else if (delay_cnt_q != '0) begin
      delay_cnt_q <= delay_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (delay_cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

`default_nettype wire

// File: logic/soc_top.sv
// SoC harness top level that connects the bus crossbar, memories, timer and debug control
`default_nettype none

module soc_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            rtc_i,
  input  logic                            ndmreset_i,
  input  logic                            debug_req_i,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [soc_pkg::AddrWidth-1:0]   addr_i,
  input  logic [soc_pkg::BeWidth-1:0]     be_i,
  input  logic [soc_pkg::DataWidth-1:0]   wdata_i,
  output logic                            rvalid_o,
  output logic [soc_pkg::DataWidth-1:0]   rdata_o,
  output logic                            err_o,
  output logic                            timer_irq_o,
  output logic                            debug_req_o
);

  logic                                periph_rst_n;

  logic                                rom_req;
  logic [soc_pkg::RomIdxWidth-1:0]     rom_idx;
  logic [soc_pkg::DataWidth-1:0]       rom_rdata;

  logic                                sram_req;
  logic                                sram_we;
  logic [soc_pkg::BeWidth-1:0]         sram_be;
  logic [soc_pkg::SramIdxWidth-1:0]    sram_idx;
  logic [soc_pkg::DataWidth-1:0]       sram_wdata;
  logic [soc_pkg::DataWidth-1:0]       sram_rdata;

  logic                                clint_req;
  logic                                clint_we;
  logic [soc_pkg::BeWidth-1:0]         clint_be;
  logic [soc_pkg::ClintOffWidth-1:0]   clint_off;
  logic [soc_pkg::DataWidth-1:0]       clint_wdata;
  logic [soc_pkg::DataWidth-1:0]       clint_rdata;

  // ---------------------------------------------------------------------
  // Reset and debug
  // ---------------------------------------------------------------------
  debug_ctrl i_debug_ctrl (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .ndmreset_i    ( ndmreset_i   ),
    .debug_req_i   ( debug_req_i  ),
    .periph_rst_no ( periph_rst_n ),
    .debug_req_o   ( debug_req_o  )
  );

  // ---------------------------------------------------------------------
  // Crossbar
  // ---------------------------------------------------------------------
  soc_xbar i_soc_xbar (
    .clk_i         ( clk_i        ),
    .periph_rst_ni ( periph_rst_n ),
    .req_i         ( req_i        ),
    .we_i          ( we_i         ),
    .addr_i        ( addr_i       ),
    .be_i          ( be_i         ),
    .wdata_i       ( wdata_i      ),
    .rvalid_o      ( rvalid_o     ),
    .rdata_o       ( rdata_o      ),
    .err_o         ( err_o        ),
    .rom_req_o     ( rom_req      ),
    .rom_idx_o     ( rom_idx      ),
    .rom_rdata_i   ( rom_rdata    ),
    .sram_req_o    ( sram_req     ),
    .sram_we_o     ( sram_we      ),
    .sram_be_o     ( sram_be      ),
    .sram_idx_o    ( sram_idx     ),
    .sram_wdata_o  ( sram_wdata   ),
    .sram_rdata_i  ( sram_rdata   ),
    .clint_req_o   ( clint_req    ),
    .clint_we_o    ( clint_we     ),
    .clint_be_o    ( clint_be     ),
    .clint_off_o   ( clint_off    ),
    .clint_wdata_o ( clint_wdata  ),
    .clint_rdata_i ( clint_rdata  )
  );

  // ---------------------------------------------------------------------
  // Targets
  // ---------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .idx_i   ( rom_idx   ),
    .rdata_o ( rom_rdata )
  );

  // SRAM contents survive the peripheral reset
  data_sram #(
    .NumWords ( soc_pkg::SramWords )
  ) i_data_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .be_i    ( sram_be    ),
    .idx_i   ( sram_idx   ),
    .wdata_i ( sram_wdata ),
    .rdata_o ( sram_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i        ),
    .rst_ni      ( periph_rst_n ),
    .rtc_i       ( rtc_i        ),
    .req_i       ( clint_req    ),
    .we_i        ( clint_we     ),
    .be_i        ( clint_be     ),
    .off_i       ( clint_off    ),
    .wdata_i     ( clint_wdata  ),
    .rdata_o     ( clint_rdata  ),
    .timer_irq_o ( timer_irq_o  )
  );

endmodule

`default_nettype wire

// File: mem/boot_rom.sv
// Boot ROM with fixed code words from the package and a registered read port
`default_nettype none

module boot_rom (
  input  logic                            clk_i,
  input  logic                            req_i,
  input  logic [soc_pkg::RomIdxWidth-1:0] idx_i,
  output logic [soc_pkg::DataWidth-1:0]   rdata_o
);

  logic [soc_pkg::DataWidth-1:0] rom_table [soc_pkg::RomWords];
  logic [soc_pkg::DataWidth-1:0] rom_word;

  // Entry code first, padded with nops
  always_comb begin
    for (int i = 0; i < soc_pkg::RomWords; i++) begin
      rom_table[i] = (i == 0) ? soc_pkg::RomBootWord : soc_pkg::RomNopWord;
    end
  end

  always_comb begin
    rom_word = '0;
    if (int'(idx_i) < soc_pkg::RomWords) begin
      rom_word = rom_table[idx_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom_word;
    end
  end

endmodule

`default_nettype wire

// File: mem/data_sram.sv
// Word-addressed data SRAM with per-byte write enables and a registered read
`default_nettype none

module data_sram #(
  parameter int unsigned NumWords = soc_pkg::SramWords
) (
  input  logic                          clk_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::BeWidth-1:0]   be_i,
  input  logic [$clog2(NumWords)-1:0]   idx_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o
);

  logic [soc_pkg::DataWidth-1:0] mem [NumWords];

  // Contents keep their value across peripheral reset
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[idx_i] <= soc_pkg::merge_bytes(mem[idx_i], wdata_i, be_i);
        rdata_o    <= '0;
      end else begin
        rdata_o <= mem[idx_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: tb.f
common/soc_pkg.sv
logic/debug_ctrl.sv
logic/clint_timer.sv
xbar/soc_xbar.sv
mem/boot_rom.sv
mem/data_sram.sv
logic/soc_top.sv
test/soc_asserts.sv
test/tb_soc.sv

// File: test/soc_asserts.sv
// Bus response and debug gate assertions, bound into soc_top during simulation
`default_nettype none

module soc_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic periph_rst_ni,
  input logic req_i,
  input logic rvalid_i,
  input logic err_i,
  input logic debug_gated_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [soc_pkg::DebugCntWidth-1:0] gate_cnt_q;

  // Edges seen since power-on reset released, saturating at the window length
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gate_cnt_q <= '0;
    end else if (gate_cnt_q < soc_pkg::DebugCntWidth'(soc_pkg::DebugDelayCycles)) begin
      gate_cnt_q <= gate_cnt_q + 1'b1;
    end
  end

  // ---------------------------------------------------------------------
  // Bus
  // ---------------------------------------------------------------------
  a_rvalid_after_req: assert property (
    @(posedge clk_i) disable iff (!periph_rst_ni) req_i |=> rvalid_i
  ) else $error("rvalid missing one cycle after a request");

  a_no_spurious_rvalid: assert property (
    @(posedge clk_i) disable iff (!periph_rst_ni) !req_i |=> !rvalid_i
  ) else $error("rvalid without a request in the cycle before");

  a_err_needs_rvalid: assert property (
    @(posedge clk_i) err_i |-> rvalid_i
  ) else $error("err high without rvalid");

  // ---------------------------------------------------------------------
  // Debug gate
  // ---------------------------------------------------------------------
  a_debug_gated: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (gate_cnt_q < soc_pkg::DebugCntWidth'(soc_pkg::DebugDelayCycles)) |-> !debug_gated_i
  ) else $error("debug request passed during the hold-off window");

endmodule

bind soc_top soc_asserts i_soc_asserts (
  .clk_i         ( clk_i        ),
  .rst_ni        ( rst_ni       ),
  .periph_rst_ni ( periph_rst_n ),
  .req_i         ( req_i        ),
  .rvalid_i      ( rvalid_o     ),
  .err_i         ( err_o        ),
  .debug_gated_i ( debug_req_o  )
);

`default_nettype wire

// File: test/tb_soc.sv
// Directed testbench for soc_top: debug gate, memory map, timer and peripheral reset
`default_nettype none

module tb_soc;
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum {OpRead, OpWrite, OpRtc, OpNdm, OpIrq} op_e;

  logic                            clk;
  logic                            rst_n;
  logic                            rtc;
  logic                            ndmreset;
  logic                            debug_req;
  logic                            req;
  logic                            we;
  logic [soc_pkg::AddrWidth-1:0]   addr;
  logic [soc_pkg::BeWidth-1:0]     be;
  logic [soc_pkg::DataWidth-1:0]   wdata;
  logic                            rvalid;
  logic [soc_pkg::DataWidth-1:0]   rdata;
  logic                            err;
  logic                            timer_irq;
  logic                            debug_req_out;

  // Stimulus table, one column per queue
  string                           t_name[$];
  op_e                             t_op[$];
  logic [soc_pkg::AddrWidth-1:0]   t_addr[$];
  logic [soc_pkg::BeWidth-1:0]     t_be[$];
  logic [soc_pkg::DataWidth-1:0]   t_wdata[$];
  logic [soc_pkg::DataWidth-1:0]   t_exp[$];
  logic                            t_err[$];

  int                              n_tests = 0;
  int                              n_fail  = 0;
  int                              cycles  = 0;
  int                              limit   = 200;
  logic [31:0]                     lcg_state = 32'he53e_4905;

  soc_top UUT (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .rtc_i       ( rtc           ),
    .ndmreset_i  ( ndmreset      ),
    .debug_req_i ( debug_req     ),
    .req_i       ( req           ),
    .we_i        ( we            ),
    .addr_i      ( addr          ),
    .be_i        ( be            ),
    .wdata_i     ( wdata         ),
    .rvalid_o    ( rvalid        ),
    .rdata_o     ( rdata         ),
    .err_o       ( err           ),
    .timer_irq_o ( timer_irq     ),
    .debug_req_o ( debug_req_out )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic add_entry(input string name, input op_e op, input logic [31:0] a,
                           input logic [7:0] b, input logic [63:0] d,
                           input logic [63:0] exp, input logic exp_err);
    t_name.push_back(name);
    t_op.push_back(op);
    t_addr.push_back(a);
    t_be.push_back(b);
    t_wdata.push_back(d);
    t_exp.push_back(exp);
    t_err.push_back(exp_err);
  endtask

  // ---------------------------------------------------------------------
  // Test table
  // ---------------------------------------------------------------------
  task automatic build_table();
    logic [63:0] d [4];
    logic [63:0] part;
    logic [63:0] mask;
    logic [31:0] t_off;
    logic [31:0] c_off;
    for (int i = 0; i < 4; i++) begin
      d[i] = {lcg_next(), lcg_next()};
    end
    part  = {lcg_next(), lcg_next()};
    // Bytes 0, 4 and 5
    mask  = 64'h0000_FFFF_0000_00FF;
    t_off = soc_pkg::ClintBase + 32'(soc_pkg::ClintTimeOffset);
    c_off = soc_pkg::ClintBase + 32'(soc_pkg::ClintCmpOffset);
    for (int i = 0; i < soc_pkg::RomWords; i++) begin
      add_entry($sformatf("rom_rd_%0d", i), OpRead, soc_pkg::RomBase + 32'(i * 8), '1, '0,
                (i == 0) ? soc_pkg::RomBootWord : soc_pkg::RomNopWord, 1'b0);
    end
    add_entry("rom_wr_reject", OpWrite, soc_pkg::RomBase, '1, 64'h1234, '0, 1'b1);
    for (int i = 0; i < 4; i++) begin
      add_entry($sformatf("sram_wr_%0d", i), OpWrite, soc_pkg::SramBase + 32'(i * 40), '1,
                d[i], '0, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      add_entry($sformatf("sram_rd_%0d", i), OpRead, soc_pkg::SramBase + 32'(i * 40), '1,
                '0, d[i], 1'b0);
    end
    add_entry("sram_wr_partial", OpWrite, soc_pkg::SramBase + 32'd40, 8'b0011_0001, part,
              '0, 1'b0);
    add_entry("sram_rd_merged", OpRead, soc_pkg::SramBase + 32'd40, '1, '0,
              (d[1] & ~mask) | (part & mask), 1'b0);
    add_entry("gpio_rd", OpRead, 32'h4000_0000, '1, '0, '0, 1'b1);
    add_entry("gpio_wr", OpWrite, 32'h4000_0008, '1, 64'hdead, '0, 1'b1);
    add_entry("past_sram_rd", OpRead, soc_pkg::SramBase + soc_pkg::SramSize, '1, '0, '0, 1'b1);
    add_entry("zero_page_rd", OpRead, 32'h0000_0000, '1, '0, '0, 1'b1);
    add_entry("rom_rd_after_err", OpRead, soc_pkg::RomBase, '1, '0, soc_pkg::RomBootWord, 1'b0);
    add_entry("mtime_rd_reset", OpRead, t_off, '1, '0, '0, 1'b0);
    add_entry("mtimecmp_rd_reset", OpRead, c_off, '1, '0, '1, 1'b0);
    add_entry("rtc_x4", OpRtc, '0, '0, 64'd4, '0, 1'b0);
    add_entry("mtime_rd_4", OpRead, t_off, '1, '0, 64'd4, 1'b0);
    add_entry("mtimecmp_wr_7", OpWrite, c_off, '1, 64'd7, '0, 1'b0);
    add_entry("mtimecmp_rd_7", OpRead, c_off, '1, '0, 64'd7, 1'b0);
    add_entry("irq_low_at_4", OpIrq, '0, '0, '0, 64'd0, 1'b0);
    add_entry("rtc_x2", OpRtc, '0, '0, 64'd2, '0, 1'b0);
    add_entry("irq_low_at_6", OpIrq, '0, '0, '0, 64'd0, 1'b0);
    add_entry("rtc_x1", OpRtc, '0, '0, 64'd1, '0, 1'b0);
    add_entry("irq_high_at_7", OpIrq, '0, '0, '0, 64'd1, 1'b0);
    add_entry("mtime_rd_7", OpRead, t_off, '1, '0, 64'd7, 1'b0);
    add_entry("ndmreset_pulse", OpNdm, '0, '0, '0, '0, 1'b0);
    add_entry("mtime_rd_ndm", OpRead, t_off, '1, '0, '0, 1'b0);
    add_entry("mtimecmp_rd_ndm", OpRead, c_off, '1, '0, '1, 1'b0);
    add_entry("irq_low_ndm", OpIrq, '0, '0, '0, 64'd0, 1'b0);
    add_entry("sram_keep_0", OpRead, soc_pkg::SramBase, '1, '0, d[0], 1'b0);
    add_entry("sram_keep_1", OpRead, soc_pkg::SramBase + 32'd40, '1, '0,
              (d[1] & ~mask) | (part & mask), 1'b0);
    add_entry("sram_keep_3", OpRead, soc_pkg::SramBase + 32'd120, '1, '0, d[3], 1'b0);
  endtask

  // ---------------------------------------------------------------------
  // Drivers, all entered and left 2 ns after a rising edge
  // ---------------------------------------------------------------------
  task automatic pulse_rtc();
    rtc = 1'b1;
    repeat (3) @(posedge clk);
    #2 rtc = 1'b0;
    repeat (3) @(posedge clk);
    #2;
  endtask

  task automatic pulse_ndmreset(inout int errs);
    ndmreset = 1'b1;
    req      = 1'b1;
    we       = 1'b0;
    addr     = soc_pkg::SramBase;
    @(posedge clk);
    #1;
    if (rvalid !== 1'b0) begin
      $display("ndmreset_pulse: request during peripheral reset got a response");
      errs++;
    end
    #1;
    req      = 1'b0;
    ndmreset = 1'b0;
    repeat (4) @(posedge clk);
    #2;
  endtask

  task automatic report(input string name, input int errs);
    n_tests++;
    if (errs != 0) begin
      n_fail++;
      $display("[FAIL] %s", name);
    end else begin
      $display("[PASS] %s", name);
    end
  endtask

  task automatic check_debug_gate();
    int errs;
    errs = 0;
    for (int k = 1; k <= soc_pkg::DebugDelayCycles + 2; k++) begin
      @(posedge clk);
      #1;
      if (debug_req_out !== (k >= soc_pkg::DebugDelayCycles)) begin
        $display("ERR debug_gate_edge_%0d expected %b actual %b", k,
                 (k >= soc_pkg::DebugDelayCycles), debug_req_out);
        errs++;
      end
    end
    #1;
    report("debug_gate", errs);
  endtask

  task automatic run_entry(input int i);
    int errs;
    errs = 0;
    case (t_op[i])
      OpRead, OpWrite: begin
        req   = 1'b1;
        we    = (t_op[i] == OpWrite);
        addr  = t_addr[i];
        be    = t_be[i];
        wdata = t_wdata[i];
        @(posedge clk);
        #1;
        if (rvalid !== 1'b1) begin
          $display("%s: no response one cycle after the request", t_name[i]);
          errs++;
        end
        if (rdata !== t_exp[i]) begin
          $display("ERR %s expected %h actual %h", t_name[i], t_exp[i], rdata);
          errs++;
        end
        if (err !== t_err[i]) begin
          $display("ERR %s err expected %b actual %b", t_name[i], t_err[i], err);
          errs++;
        end
        #1;
        req = 1'b0;
        we  = 1'b0;
      end
      OpRtc: begin
        repeat (int'(t_wdata[i])) pulse_rtc();
      end
      OpNdm: begin
        pulse_ndmreset(errs);
      end
      OpIrq: begin
        if (timer_irq !== t_exp[i][0]) begin
          $display("ERR %s expected %b actual %b", t_name[i], t_exp[i][0], timer_irq);
          errs++;
        end
      end
    endcase
    report(t_name[i], errs);
  endtask

  initial begin
    rst_n     = 1'b0;
    rtc       = 1'b0;
    ndmreset  = 1'b0;
    debug_req = 1'b1;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    be        = '0;
    wdata     = '0;
    build_table();
    limit = t_name.size() * 4 + 200;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
    check_debug_gate();
    for (int i = 0; i < t_name.size(); i++) begin
      run_entry(i);
    end
    $display("%0d tests run, %0d failed", n_tests, n_fail);
    if (n_fail == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: xbar/soc_xbar.sv
// Strobe bus crossbar: decodes the address map, steers requests and builds the response
`default_nettype none

module soc_xbar (
  input  logic                              clk_i,
  input  logic                              periph_rst_ni,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [soc_pkg::AddrWidth-1:0]     addr_i,
  input  logic [soc_pkg::BeWidth-1:0]       be_i,
  input  logic [soc_pkg::DataWidth-1:0]     wdata_i,
  output logic                              rvalid_o,
  output logic [soc_pkg::DataWidth-1:0]     rdata_o,
  output logic                              err_o,
  output logic                              rom_req_o,
  output logic [soc_pkg::RomIdxWidth-1:0]   rom_idx_o,
  input  logic [soc_pkg::DataWidth-1:0]     rom_rdata_i,
  output logic                              sram_req_o,
  output logic                              sram_we_o,
  output logic [soc_pkg::BeWidth-1:0]       sram_be_o,
  output logic [soc_pkg::SramIdxWidth-1:0]  sram_idx_o,
  output logic [soc_pkg::DataWidth-1:0]     sram_wdata_o,
  input  logic [soc_pkg::DataWidth-1:0]     sram_rdata_i,
  output logic                              clint_req_o,
  output logic                              clint_we_o,
  output logic [soc_pkg::BeWidth-1:0]       clint_be_o,
  output logic [soc_pkg::ClintOffWidth-1:0] clint_off_o,
  output logic [soc_pkg::DataWidth-1:0]     clint_wdata_o,
  input  logic [soc_pkg::DataWidth-1:0]     clint_rdata_i
);

  soc_pkg::region_e region;
  soc_pkg::region_e region_q;
  logic             rvalid_q;
  logic             err_q;

  // ---------------------------------------------------------------------
  // Address decode
  // ---------------------------------------------------------------------
  always_comb begin
    if (addr_i >= soc_pkg::RomBase && addr_i < soc_pkg::RomBase + soc_pkg::RomSize) begin
      // Writes into ROM are rejected like unmapped space
      region = we_i ? soc_pkg::RegionErr : soc_pkg::RegionRom;
    end else if (addr_i >= soc_pkg::SramBase &&
                 addr_i < soc_pkg::SramBase + soc_pkg::SramSize) begin
      region = soc_pkg::RegionSram;
    end else if (addr_i >= soc_pkg::ClintBase &&
                 addr_i < soc_pkg::ClintBase + soc_pkg::ClintSize) begin
      region = soc_pkg::RegionClint;
    end else begin
      region = soc_pkg::RegionErr;
    end
  end

  // ---------------------------------------------------------------------
  // Request steering
  // ---------------------------------------------------------------------
  assign rom_req_o = req_i && (region == soc_pkg::RegionRom);
  assign rom_idx_o = addr_i[soc_pkg::WordOffsetBits +: soc_pkg::RomIdxWidth];

  assign sram_req_o   = req_i && (region == soc_pkg::RegionSram);
  assign sram_we_o    = we_i;
  assign sram_be_o    = be_i;
  assign sram_idx_o   = addr_i[soc_pkg::WordOffsetBits +: soc_pkg::SramIdxWidth];
  assign sram_wdata_o = wdata_i;

  assign clint_req_o   = req_i && (region == soc_pkg::RegionClint);
  assign clint_we_o    = we_i;
  assign clint_be_o    = be_i;
  assign clint_off_o   = addr_i[soc_pkg::ClintOffWidth-1:0];
  assign clint_wdata_o = wdata_i;

  // ---------------------------------------------------------------------
  // Response
  // ---------------------------------------------------------------------
  // Held clear during peripheral reset, so those requests get no response
  always_ff @(posedge clk_i or negedge periph_rst_ni) begin
    if (!periph_rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      region_q <= soc_pkg::RegionErr;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i && (region == soc_pkg::RegionErr);
      if (req_i) begin
        region_q <= region;
      end
    end
  end

  always_comb begin
    case (region_q)
      soc_pkg::RegionRom:   rdata_o = rom_rdata_i;
      soc_pkg::RegionSram:  rdata_o = sram_rdata_i;
      soc_pkg::RegionClint: rdata_o = clint_rdata_i;
      default:              rdata_o = '0;
    endcase
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

endmodule

`default_nettype wire
